// ==== list.f ====
+incdir+testbench
verilog/alu_pkg.sv
verilog/alu_adder.sv
verilog/alu_shifter.sv
verilog/alu_compare.sv
verilog/alu_bitcount.sv
verilog/alu.sv
testbench/tb_alu.sv

// ==== Bender.yml ====
package:
  name: alu

sources:
  - verilog/alu_pkg.sv
  - verilog/alu_adder.sv
  - verilog/alu_shifter.sv
  - verilog/alu_compare.sv
  - verilog/alu_bitcount.sv
  - verilog/alu.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_alu.sv

// ==== testbench/alu_model.svh ====
/*
 * ALU reference model
 * Expected result word and comparison bit, worked out from the RV32
 * integer and bitmanip rules for every opcode
 */

`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

  // Zeros above the highest set bit
  function automatic int leading_zeros(input logic [XLEN-1:0] w);
    int n;
    n = 0;
    while (n < XLEN && w[XLEN-1-n] == 1'b0)
      n++;
    return n;
  endfunction

  // Zeros below the lowest set bit
  function automatic int trailing_zeros(input logic [XLEN-1:0] w);
    int n;
    n = 0;
    while (n < XLEN && w[n] == 1'b0)
      n++;
    return n;
  endfunction

  function automatic logic [XLEN-1:0] expected_result(input alu_op_e op,
                                                      input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b);
    logic [SHAMT_W-1:0] sh;
    // Only the low bits of b give the amount
    sh = b[SHAMT_W-1:0];
    case (op)
      ALU_AND:    return a & b;
      ALU_OR:     return a | b;
      ALU_XOR:    return a ^ b;
      // Wraparound modulo 2**32
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_SH1ADD: return (a << 1) + b;
      ALU_SH2ADD: return (a << 2) + b;
      ALU_SH3ADD: return (a << 3) + b;
      ALU_SLL:    return a << sh;
      ALU_SRL:    return a >> sh;
      ALU_SRA:    return $signed(a) >>> sh;
      ALU_SLTS:   return XLEN'($signed(a) < $signed(b));
      ALU_SLTU:   return XLEN'(a < b);
      ALU_CLZ:    return XLEN'(leading_zeros(a));
      ALU_CTZ:    return XLEN'(trailing_zeros(a));
      ALU_CPOP:   return XLEN'($countones(a));
      ALU_MIN:    return ($signed(a) < $signed(b)) ? a : b;
      ALU_MINU:   return (a < b) ? a : b;
      ALU_MAX:    return ($signed(a) > $signed(b)) ? a : b;
      ALU_MAXU:   return (a > b) ? a : b;
      // Branch compares leave the word at zero
      default:    return '0;
    endcase
  endfunction

  // Comparison bit, set only by branch and SLT opcodes
  function automatic logic expected_cmp(input alu_op_e op,
                                        input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (op)
      ALU_EQ:             return a == b;
      ALU_NE:             return a != b;
      ALU_GES:            return $signed(a) >= $signed(b);
      ALU_GEU:            return a >= b;
      ALU_LTS, ALU_SLTS:  return $signed(a) < $signed(b);
      ALU_LTU, ALU_SLTU:  return a < b;
      default:            return 1'b0;
    endcase
  endfunction

`endif

// ==== testbench/tb_alu.sv ====
/*
 * ALU testbench
 * LFSR operands driven on the falling edge
 * Every valid cycle checked against the reference model by concurrent assertions
 */

`timescale 1ns/10ps

module tb_alu;

  import alu_pkg::*;

  `include "alu_model.svh"

  localparam int CLK_PERIOD = 4;
  localparam int N_RAND     = 200;
  localparam int N_SMALL    = 50;
  localparam int N_EDGE     = 10;
  localparam int N_HS       = 100;
  // Vectors over all six tests
  localparam int TOTAL_VECS = 8 * (N_RAND + 2) + 3 * 2 * XLEN + 8 * (N_SMALL + 2 * N_EDGE)
                            + 3 * (N_SMALL + 2 + XLEN) + 4 * (N_SMALL + N_EDGE) + N_HS;
  // Slack for reset and the test ends
  localparam int MARGIN     = 200;

  logic          clk = 1'b0;
  logic          arst_n_i;
  alu_op_e       operator_i;
  alu_operands_t operands_i;
  logic          valid_i;
  logic          ready_i;
  alu_result_t   res_o;
  logic          valid_o;
  logic          ready_o;

  logic [31:0] lfsr_state = 32'h2fff;
  int          error_count = 0;
  int          vec_count = 0;
  int          test_count = 0;
  int          err_mark;
  int          vec_mark;

  // One opcode group per test
  alu_op_e arith_ops[8]  = '{ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB,
                             ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD};
  alu_op_e shift_ops[3]  = '{ALU_SLL, ALU_SRL, ALU_SRA};
  alu_op_e cmp_ops[8]    = '{ALU_EQ, ALU_NE, ALU_GES, ALU_GEU, ALU_LTS, ALU_LTU,
                             ALU_SLTS, ALU_SLTU};
  alu_op_e count_ops[3]  = '{ALU_CLZ, ALU_CTZ, ALU_CPOP};
  alu_op_e minmax_ops[4] = '{ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU};

  alu dut_i (
    .clk        ( clk        ),
    .arst_n_i   ( arst_n_i   ),
    .operator_i ( operator_i ),
    .operands_i ( operands_i ),
    .valid_i    ( valid_i    ),
    .ready_i    ( ready_i    ),
    .res_o      ( res_o      ),
    .valid_o    ( valid_o    ),
    .ready_o    ( ready_o    )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Galois LFSR with taps 32 22 2 1
  // One step per bit taken
  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] w;
    w = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      w = {w[XLEN-2:0], lfsr_state[0]};
    end
    return w;
  endfunction

  task automatic apply(input alu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    @(negedge clk);
    operator_i   = op;
    operands_i.a = a;
    operands_i.b = b;
    valid_i      = 1'b1;
    vec_count++;
  endtask

  // Mode 0 gives a free pair, 1 an equal pair and 2 opposite sign bits
  task automatic apply_pair(input alu_op_e op, input int mode);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = rand_bits(XLEN);
    b = (mode == 1) ? a : rand_bits(XLEN);
    if (mode == 2)
      b[XLEN-1] = ~a[XLEN-1];
    apply(op, a, b);
  endtask

  task automatic begin_test();
    err_mark = error_count;
    vec_mark = vec_count;
  endtask

  // One more edge so the last vector gets sampled
  task automatic end_test(input string name);
    @(negedge clk);
    test_count++;
    $display("Test %-10s %5d vectors, %0d errors", name, vec_count - vec_mark,
             error_count - err_mark);
  endtask

  task automatic report_mismatch(input string what);
    error_count++;
    $display("Mismatch at %0d ns: %s, op %s a %h b %h", $time, what, operator_i.name(),
             operands_i.a, operands_i.b);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge clk) disable iff (!arst_n_i)
    valid_i |-> res_o.result == expected_result(operator_i, operands_i.a, operands_i.b))
    else report_mismatch("result word");

  assert property (@(posedge clk) disable iff (!arst_n_i)
    valid_i |-> res_o.cmp == expected_cmp(operator_i, operands_i.a, operands_i.b))
    else report_mismatch("comparison bit");

  // Handshake is checked in reset too
  assert property (@(posedge clk) valid_o == valid_i)
    else report_mismatch("valid_o does not follow valid_i");

  assert property (@(posedge clk) ready_o == ready_i)
    else report_mismatch("ready_o does not follow ready_i");

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial
  begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    arst_n_i   = 1'b0;
    operator_i = ALU_ADD;
    operands_i = '0;
    valid_i    = 1'b0;
    ready_i    = 1'b0;
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;
    ready_i  = 1'b1;

    begin_test();
    foreach (arith_ops[k])
    begin
      repeat (N_RAND) apply_pair(arith_ops[k], 0);
      apply_pair(arith_ops[k], 1);
      apply(arith_ops[k], rand_bits(XLEN), '0);
    end
    end_test("arith");

    // Every amount with random upper bits of b and a negative a on the second vector
    begin_test();
    foreach (shift_ops[k])
    begin
      for (int s = 0; s < XLEN; s++)
      begin
        a = rand_bits(XLEN);
        b = (rand_bits(XLEN - SHAMT_W) << SHAMT_W) | XLEN'(s);
        apply(shift_ops[k], a, b);
        apply(shift_ops[k], {1'b1, a[XLEN-2:0]}, b);
      end
    end
    end_test("shift");

    begin_test();
    foreach (cmp_ops[k])
    begin
      repeat (N_SMALL) apply_pair(cmp_ops[k], 0);
      repeat (N_EDGE) apply_pair(cmp_ops[k], 1);
      repeat (N_EDGE) apply_pair(cmp_ops[k], 2);
    end
    end_test("compare");

    // Zero, all ones and each single-bit word
    begin_test();
    foreach (count_ops[k])
    begin
      repeat (N_SMALL) apply_pair(count_ops[k], 0);
      apply(count_ops[k], '0, '0);
      apply(count_ops[k], '1, '0);
      for (int i = 0; i < XLEN; i++)
        apply(count_ops[k], XLEN'(1) << i, '0);
    end
    end_test("bitcount");

    begin_test();
    foreach (minmax_ops[k])
    begin
      repeat (N_SMALL) apply_pair(minmax_ops[k], 0);
      repeat (N_EDGE) apply_pair(minmax_ops[k], 2);
    end
    end_test("minmax");

    // Two cycles in reset and then random toggling right after release
    begin_test();
    for (int n = 0; n < N_HS; n++)
    begin
      @(negedge clk);
      arst_n_i     = (n >= 2);
      valid_i      = 1'(rand_bits(1));
      ready_i      = 1'(rand_bits(1));
      operator_i   = ALU_ADD;
      operands_i.a = rand_bits(XLEN);
      operands_i.b = rand_bits(XLEN);
      vec_count++;
    end
    end_test("handshake");

    $display("%0d tests, %0d vectors, %0d errors", test_count, vec_count, error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    #(CLK_PERIOD * (TOTAL_VECS + MARGIN));
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== verilog/alu.sv ====
/*
 * Integer ALU, top level
 * Single-cycle RV32 ALU built from adder, shifter, comparator and
 * bit counter, with the result picked by opcode
 * Valid and ready pass straight through, nothing is registered
 */

`timescale 1ns/10ps

module alu (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  alu_pkg::alu_op_e        operator_i,
  input  alu_pkg::alu_operands_t  operands_i,
  input  logic                    valid_i,
  input  logic                    ready_i,
  output alu_pkg::alu_result_t    res_o,
  output logic                    valid_o,
  output logic                    ready_o
);

  import alu_pkg::*;

  logic [XLEN-1:0]  sum;
  logic [XLEN-1:0]  shift_res;
  logic             cmp;
  logic [XLEN-1:0]  minmax;
  logic [CNT_W-1:0] count;

  //////////////////////////////
  // Blocks
  //////////////////////////////

  alu_adder adder_i (
    .operator_i ( operator_i ),
    .operands_i ( operands_i ),
    .sum_o      ( sum        )
  );

  alu_shifter shifter_i (
    .operator_i ( operator_i ),
    .operands_i ( operands_i ),
    .shift_o    ( shift_res  )
  );

  alu_compare compare_i (
    .operator_i ( operator_i ),
    .operands_i ( operands_i ),
    .cmp_o      ( cmp        ),
    .minmax_o   ( minmax     )
  );

  // Counts always look at operand a
  alu_bitcount bitcount_i (
    .operator_i ( operator_i   ),
    .operand_i  ( operands_i.a ),
    .count_o    ( count        )
  );

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb
  begin
    // Branch compares leave the word at zero
    res_o.result = '0;
    unique case (operator_i)
      // Logic ops, too small for a block of their own
      ALU_AND: res_o.result = operands_i.a & operands_i.b;
      ALU_OR:  res_o.result = operands_i.a | operands_i.b;
      ALU_XOR: res_o.result = operands_i.a ^ operands_i.b;
      ALU_ADD, ALU_SUB,
      ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD: res_o.result = sum;
      ALU_SLL, ALU_SRL, ALU_SRA: res_o.result = shift_res;
      ALU_SLTS, ALU_SLTU: res_o.result = {{(XLEN-1){1'b0}}, cmp};
      ALU_CLZ, ALU_CTZ, ALU_CPOP: res_o.result = {{(XLEN-CNT_W){1'b0}}, count};
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: res_o.result = minmax;
      default: ;
    endcase
  end

  assign res_o.cmp = cmp;

  // Combinational unit, handshake goes straight through
  assign valid_o = valid_i;
  assign ready_o = ready_i;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // No latency anywhere on the valid path
  assert property (@(posedge clk) disable iff (!arst_n_i) valid_o == valid_i)
    else $error("valid_o does not follow valid_i");

  // Inverted b plus carry-in through the adder gives a true difference
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   (valid_i && operator_i == ALU_SUB)
                   |-> res_o.result == operands_i.a - operands_i.b)
    else $error("SUB result differs from a - b");

endmodule

// ==== verilog/alu_bitcount.sv ====
/*
 * ALU bit counter
 * CLZ and CTZ through a find-first-one from the low end,
 * CLZ working on the bit-reversed operand
 * CPOP as a plain sum of the operand bits
 */

`timescale 1ns/10ps

module alu_bitcount (
  input  alu_pkg::alu_op_e            operator_i,
  input  logic [alu_pkg::XLEN-1:0]    operand_i,
  output logic [alu_pkg::CNT_W-1:0]   count_o
);

  import alu_pkg::*;

  logic [XLEN-1:0]    operand_rev;
  logic [XLEN-1:0]    ff1_in;
  logic [SHAMT_W-1:0] ff1_idx;
  logic               no_ones;
  logic [CNT_W-1:0]   zero_cnt;
  logic [CNT_W-1:0]   pop_cnt;

  //////////////////////////////
  // Leading and trailing zeros
  //////////////////////////////

  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
    begin
      operand_rev[i] = operand_i[XLEN-1-i];
    end
  end

  // Leading zeros of a are trailing zeros of its reverse
  assign ff1_in = (operator_i == ALU_CLZ) ? operand_rev : operand_i;

  // Scan from the top down so the lowest set bit wins
  always_comb
  begin
    ff1_idx = '0;
    for (int i = XLEN-1; i >= 0; i--)
    begin
      if (ff1_in[i])
        ff1_idx = SHAMT_W'(i);
    end
  end

  assign no_ones = ~|ff1_in;

  // All zero word counts the full width
  assign zero_cnt = no_ones ? CNT_W'(XLEN) : {1'b0, ff1_idx};

  //////////////////////////////
  // Population count
  //////////////////////////////

  always_comb
  begin
    pop_cnt = '0;
    for (int i = 0; i < XLEN; i++)
    begin
      pop_cnt = pop_cnt + CNT_W'(operand_i[i]);
    end
  end

  assign count_o = (operator_i == ALU_CPOP) ? pop_cnt : zero_cnt;

  // Count range check, covers the no-ones path and the popcount sum
  always_comb
  begin
    assert final (count_o <= CNT_W'(XLEN))
      else $error("Bit count above the data width");
  end

endmodule

// ==== verilog/alu_compare.sv ====
/*
 * ALU comparator
 * Equal and greater-than on sign- or zero-extended operands
 * Drives the branch and SLT comparison bit and the min/max selection
 */

`timescale 1ns/10ps

module alu_compare (
  input  alu_pkg::alu_op_e            operator_i,
  input  alu_pkg::alu_operands_t      operands_i,
  output logic                        cmp_o,
  output logic [alu_pkg::XLEN-1:0]    minmax_o
);

  import alu_pkg::*;

  logic          cmp_signed;
  logic [XLEN:0] ext_a;
  logic [XLEN:0] ext_b;
  logic          is_equal;
  logic          is_greater;

  //////////////////////////////
  // Order
  //////////////////////////////

  // Signed flavours, MIN and MAX included
  assign cmp_signed = (operator_i == ALU_GES)  ||
                      (operator_i == ALU_LTS)  ||
                      (operator_i == ALU_SLTS) ||
                      (operator_i == ALU_MIN)  ||
                      (operator_i == ALU_MAX);

  // 33-bit values, sign bit copied only when signed
  assign ext_a = {operands_i.a[XLEN-1] & cmp_signed, operands_i.a};
  assign ext_b = {operands_i.b[XLEN-1] & cmp_signed, operands_i.b};

  assign is_equal   = (operands_i.a == operands_i.b);
  // One signed compare covers both orders
  assign is_greater = $signed(ext_a) > $signed(ext_b);

  //////////////////////////////
  // Branch and SLT bit
  //////////////////////////////

  always_comb
  begin
    unique case (operator_i)
      ALU_EQ:           cmp_o = is_equal;
      ALU_NE:           cmp_o = ~is_equal;
      ALU_GES, ALU_GEU: cmp_o = is_greater | is_equal;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU: cmp_o = ~(is_greater | is_equal);
      default:          cmp_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Min and max
  //////////////////////////////

  // On a tie either operand is the answer
  always_comb
  begin
    unique case (operator_i)
      ALU_MAX, ALU_MAXU: minmax_o = is_greater ? operands_i.a : operands_i.b;
      default:           minmax_o = is_greater ? operands_i.b : operands_i.a;
    endcase
  end

endmodule

// ==== verilog/alu_shifter.sv ====
/*
 * ALU shifter
 * Single right shifter for SRL and SRA
 * SLL reuses it by bit-reversing the input and the output
 */

`timescale 1ns/10ps

module alu_shifter (
  input  alu_pkg::alu_op_e            operator_i,
  input  alu_pkg::alu_operands_t      operands_i,
  output logic [alu_pkg::XLEN-1:0]    shift_o
);

  import alu_pkg::*;

  logic               shift_left;
  logic               shift_arith;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    a_rev;
  logic [XLEN-1:0]    shift_in;
  logic [2*XLEN-1:0]  shift_wide;
  logic [2*XLEN-1:0]  shifted_wide;
  logic [XLEN-1:0]    right_res;
  logic [XLEN-1:0]    left_res;

  assign shift_left  = (operator_i == ALU_SLL);
  // Sign fill only for SRA
  assign shift_arith = (operator_i == ALU_SRA);

  // Upper bits of b are ignored
  assign shamt = operands_i.b[SHAMT_W-1:0];

  // Reverse operand a so a left shift becomes a right shift
  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
    begin
      a_rev[i] = operands_i.a[XLEN-1-i];
    end
  end

  assign shift_in = shift_left ? a_rev : operands_i.a;

  // Upper half holds the fill bits
  assign shift_wide   = {{XLEN{shift_arith & shift_in[XLEN-1]}}, shift_in};
  assign shifted_wide = shift_wide >> shamt;
  assign right_res    = shifted_wide[XLEN-1:0];

  // Undo the reversal for SLL
  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
    begin
      left_res[i] = right_res[XLEN-1-i];
    end
  end

  assign shift_o = shift_left ? left_res : right_res;

  // Negative SRA keeps its sign through the reversal muxes
  always_comb
  begin
    if (shift_arith && operands_i.a[XLEN-1] && (shamt != '0))
      assert final (shift_o[XLEN-1])
        else $error("SRA of a negative operand lost its sign bit");
  end

endmodule

// ==== verilog/alu_adder.sv ====
/*
 * ALU adder
 * One shared adder for ADD, SUB and SH1ADD/SH2ADD/SH3ADD
 * Operand a is pre-shifted for the shift-and-add ops, operand b is
 * inverted for SUB with the +1 entering through the low carry bit
 */

`timescale 1ns/10ps

module alu_adder (
  input  alu_pkg::alu_op_e            operator_i,
  input  alu_pkg::alu_operands_t      operands_i,
  output logic [alu_pkg::XLEN-1:0]    sum_o
);

  import alu_pkg::*;

  logic            negate_b;
  logic [XLEN-1:0] add_a;
  logic [XLEN-1:0] add_b;
  logic [XLEN:0]   sum_ext;

  // Two's complement subtract
  assign negate_b = (operator_i == ALU_SUB);

  // Pre-shift of operand a for the Zba ops
  always_comb
  begin
    unique case (operator_i)
      ALU_SH1ADD: add_a = operands_i.a << 1;
      ALU_SH2ADD: add_a = operands_i.a << 2;
      ALU_SH3ADD: add_a = operands_i.a << 3;
      default:    add_a = operands_i.a;
    endcase
  end

  assign add_b = negate_b ? ~operands_i.b : operands_i.b;

  // Extra low bit carries the +1 for SUB
  // Carry out of the top is dropped, wraparound arithmetic
  assign sum_ext = {add_a, 1'b1} + {add_b, negate_b};

  assign sum_o = sum_ext[XLEN:1];

endmodule

// ==== verilog/alu_pkg.sv ====
/*
 * ALU package
 * Data widths, the ALU opcode set and the packed operand and result
 * bundles shared by every block of the integer ALU
 */

package alu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data path width
  localparam int unsigned XLEN    = 32;
  // Shift amount, enough to index XLEN bits
  localparam int unsigned SHAMT_W = 5;
  // Bit count, has to hold the value XLEN itself
  localparam int unsigned CNT_W   = 6;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  typedef enum logic [4:0] {
    // Plain arithmetic and logic
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    // Shifts
    ALU_SLL, ALU_SRL, ALU_SRA,
    // Branch comparisons, result only on the cmp bit
    ALU_EQ, ALU_NE, ALU_GES, ALU_GEU, ALU_LTS, ALU_LTU,
    // Set less than, 0 or 1 in the result word
    ALU_SLTS, ALU_SLTU,
    // Shift and add
    ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD,
    // Bit counts
    ALU_CLZ, ALU_CTZ, ALU_CPOP,
    // Min and max
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU
  } alu_op_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // Source operands, a in the upper half
  typedef struct packed {
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } alu_operands_t;

  // Result word plus the comparison bit for branches
  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            cmp;
  } alu_result_t;

endpackage
